/* verilog/dac_pkg.sv */
//////////////////////////////////////////////////////////////////////
// AD5601 controller types; DAC word layout follows the datasheet's
// 16-bit input shift register, data in 13:6, rsvd bits ignored
//////////////////////////////////////////////////////////////////////
package dac_pkg;

    localparam int ADDR_W = 4;
    localparam int DATA_W = 16;

    localparam logic [DATA_W-1:0] MODULE_VERSION = 16'd1;

    // one register per word offset
    typedef enum logic [ADDR_W-1:0] {
        ADDR_VERSION     = 4'd0,
        ADDR_DAC_REG     = 4'd1,
        ADDR_EN_MMI_CTRL = 4'd2
    } reg_addr_e;

    // power-down control bits PD1:PD0
    typedef enum logic [1:0] {
        MODE_NORMAL      = 2'b00,
        MODE_PD_1K       = 2'b01,
        MODE_PD_100K     = 2'b10,
        MODE_PD_TRISTATE = 2'b11
    } dac_mode_e;

    typedef struct packed {
        dac_mode_e  mode;
        logic [7:0] data;
        logic [5:0] rsvd;
    } dac_word_t;

    typedef struct packed {
        logic              wvalid;
        logic [ADDR_W-1:0] waddr;
        logic [DATA_W-1:0] wdata;
        logic              arvalid;
        logic [ADDR_W-1:0] raddr;
        logic              rready;
    } mmi_req_t;

    typedef struct packed {
        logic              wready;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } mmi_rsp_t;

    typedef struct packed {
        logic sclk;
        logic mosi;
        logic ssn;
    } spi_pins_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RESET_LOAD,
        ST_SHIFT
    } fsm_state_e;

endpackage

/* verilog/dac_regs.sv */
//////////////////////////////////////////////////////////////////////
// bus writes to the DAC register only count while EN_MMI_CTRL is set;
// otherwise the stream input replaces the data field alone
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dac_regs #(
    parameter dac_pkg::dac_word_t DAC_DEFAULT = '0
) (
    input  var logic               clk,
    input  var logic               peripheral_sreset,
    input  var logic               en_mmi_ctrl,
    input  var dac_pkg::mmi_req_t  mmi_req,
    output var dac_pkg::mmi_rsp_t  mmi_rsp,
    input  var logic [7:0]         dac_data_in,
    input  var logic               dac_data_in_valid_stb,
    output var dac_pkg::dac_word_t dac_word,
    output var logic               update_req
);

    import dac_pkg::*;

    dac_word_t         dac_reg_q;
    logic              en_ctrl_q;
    logic              wready_q;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] rd_mux;
    logic              wr_bus;
    logic              wr_strm;
    logic              rd_acc;

    //////////////////////////////////////////////////////////////////////
    // write source selection

    assign wr_bus  = mmi_req.wvalid && wready_q && en_ctrl_q
                     && (mmi_req.waddr == ADDR_DAC_REG);
    assign wr_strm = dac_data_in_valid_stb && !en_ctrl_q;

    // pulses in the cycle the register loads
    assign update_req = wr_bus || wr_strm;
    assign dac_word   = dac_reg_q;

    // control level mirrored into register 2
    always_ff @(posedge clk) begin
        en_ctrl_q <= en_mmi_ctrl;
    end

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            dac_reg_q <= DAC_DEFAULT;
            wready_q  <= 1'b0;
        end else begin
            wready_q <= 1'b1;
            if (wr_bus) begin
                dac_reg_q <= dac_word_t'(mmi_req.wdata);
            end else if (wr_strm) begin
                // mode and rsvd bits stay as last written
                dac_reg_q.data <= dac_data_in;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read path

    always_comb begin
        case (mmi_req.raddr)
            ADDR_VERSION:     rd_mux = MODULE_VERSION;
            ADDR_DAC_REG:     rd_mux = dac_reg_q;
            ADDR_EN_MMI_CTRL: rd_mux = {{(DATA_W-1){1'b0}}, en_ctrl_q};
            default:          rd_mux = '0;
        endcase
    end

    assign rd_acc = mmi_req.arvalid && !rvalid_q;

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            rvalid_q <= 1'b0;
        end else if (rd_acc) begin
            rvalid_q <= 1'b1;
        end else if (mmi_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata_q <= rd_mux;
        end
    end

    always_comb begin
        mmi_rsp.wready  = wready_q;
        mmi_rsp.arready = !rvalid_q;
        mmi_rsp.rvalid  = rvalid_q;
        mmi_rsp.rdata   = rdata_q;
    end

    // a stalled response holds until the master takes it
    a_read_hold: assert property (@(posedge clk) disable iff (peripheral_sreset)
        mmi_rsp.rvalid && !mmi_req.rready |=> mmi_rsp.rvalid && $stable(mmi_rsp.rdata));

endmodule

`default_nettype wire

/* verilog/dac_update_fsm.sv */
//////////////////////////////////////////////////////////////////////
// requests that land during a frame merge into one follow-up frame
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dac_update_fsm #(
    parameter bit SET_DEFAULT_ON_RESET = 1'b1
) (
    input  var logic clk,
    input  var logic peripheral_sreset,
    input  var logic update_req,
    input  var logic frame_done,
    output var logic frame_start,
    output var logic init_done,
    output var logic dac_data_in_updated_stb
);

    import dac_pkg::*;

    fsm_state_e state;
    logic       pending;

    //////////////////////////////////////////////////////////////////////
    // frame sequencing
    //
    // frame_start is raised from IDLE or RESET_LOAD and the move to
    // SHIFT happens at the end of that same cycle, so a request seen
    // while frame_start is high is already too late for this frame

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            // an active frame is dropped here
            state                   <= SET_DEFAULT_ON_RESET ? ST_RESET_LOAD : ST_IDLE;
            pending                 <= 1'b0;
            frame_start             <= 1'b0;
            init_done               <= 1'b0;
            dac_data_in_updated_stb <= 1'b0;
        end else begin
            frame_start             <= 1'b0;
            dac_data_in_updated_stb <= 1'b0;

            if (!SET_DEFAULT_ON_RESET || frame_done) begin
                init_done <= 1'b1;
            end

            case (state)
                ST_RESET_LOAD: begin
                    // default word goes out unconditionally
                    if (frame_start) begin
                        state   <= ST_SHIFT;
                        pending <= update_req;
                    end else begin
                        frame_start <= 1'b1;
                    end
                end

                ST_IDLE: begin
                    if (frame_start) begin
                        state   <= ST_SHIFT;
                        pending <= update_req;
                    end else if (update_req) begin
                        frame_start <= 1'b1;
                    end
                end

                ST_SHIFT: begin
                    if (frame_done) begin
                        dac_data_in_updated_stb <= 1'b1;
                        pending                 <= 1'b0;
                        state                   <= ST_IDLE;
                        // a request in this cycle is still picked up by the reload
                        if (pending || update_req) begin
                            frame_start <= 1'b1;
                        end
                    end else if (update_req) begin
                        pending <= 1'b1;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    // the timer and shifter would restart mid-frame otherwise
    a_no_start_in_shift: assert property (@(posedge clk) disable iff (peripheral_sreset)
        frame_start |-> state != ST_SHIFT);

endmodule

`default_nettype wire

/* verilog/spi_bit_timer.sv */
//////////////////////////////////////////////////////////////////////
// SCLK_DIV clocks per SCLK half period, must be at least 1
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spi_bit_timer #(
    parameter int SCLK_DIV = 2
) (
    input  var logic clk,
    input  var logic peripheral_sreset,
    input  var logic frame_start,
    output var logic sclk_rise,
    output var logic sclk_fall,
    output var logic frame_done
);

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

    logic             active;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    // high once the fall of the current bit has gone out
    logic             phase;
    logic             tick;

    assign tick      = active && (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign sclk_fall = tick && !phase;
    assign sclk_rise = tick && phase;

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            active     <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            phase      <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (frame_start) begin
                active  <= 1'b1;
                div_cnt <= '0;
                bit_cnt <= '0;
                phase   <= 1'b0;
            end else if (tick) begin
                div_cnt <= '0;
                phase   <= !phase;
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 4'd1;
                    // sixteenth rise ends the frame
                    if (bit_cnt == 4'd15) begin
                        active     <= 1'b0;
                        frame_done <= 1'b1;
                    end
                end
            end else if (active) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    a_edges_in_frame: assert property (@(posedge clk) disable iff (peripheral_sreset)
        (sclk_rise || sclk_fall) |-> active && !frame_done && !frame_start);

endmodule

`default_nettype wire

/* verilog/spi_shifter.sv */
//////////////////////////////////////////////////////////////////////
// SCLK idles high; MOSI moves on rises so the DAC samples on falls
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
    input  var logic               clk,
    input  var logic               peripheral_sreset,
    input  var logic               frame_start,
    input  var logic               sclk_rise,
    input  var logic               sclk_fall,
    input  var logic               frame_done,
    input  var dac_pkg::dac_word_t dac_word,
    output var dac_pkg::spi_pins_t spi
);

    logic [15:0] shift_q;

    //////////////////////////////////////////////////////////////////////
    // shift register, msb first

    always_ff @(posedge clk) begin
        if (frame_start) begin
            shift_q <= dac_word;
        end else if (sclk_rise) begin
            shift_q <= {shift_q[14:0], 1'b0};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered pins

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            spi.sclk <= 1'b1;
            spi.mosi <= 1'b0;
            spi.ssn  <= 1'b1;
        end else begin
            if (frame_start) begin
                // bit 15 is set up before the first fall
                spi.ssn  <= 1'b0;
                spi.mosi <= dac_word[15];
            end else if (frame_done) begin
                spi.ssn  <= 1'b1;
                spi.mosi <= 1'b0;
            end

            if (sclk_fall) begin
                spi.sclk <= 1'b0;
            end else if (sclk_rise) begin
                spi.sclk <= 1'b1;
                spi.mosi <= shift_q[14];
            end
        end
    end

    // the reset itself may force sclk back high with ssn released
    a_sclk_in_frame: assert property (@(posedge clk) disable iff (peripheral_sreset)
        $changed(spi.sclk) |-> !spi.ssn || $past(peripheral_sreset));

endmodule

`default_nettype wire

/* verilog/dac_ad5601_top.sv */
//////////////////////////////////////////////////////////////////////
// single reset domain; SPI pins are driven directly, no MISO
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dac_ad5601_top #(
    parameter bit                 SET_DEFAULT_ON_RESET = 1'b1,
    parameter dac_pkg::dac_word_t DAC_DEFAULT          = '{dac_pkg::MODE_NORMAL, 8'h80, 6'h00},
    parameter int                 SCLK_DIV             = 2
) (
    input  var logic               clk,
    input  var logic               peripheral_sreset,
    input  var dac_pkg::mmi_req_t  mmi_req,
    output var dac_pkg::mmi_rsp_t  mmi_rsp,
    input  var logic [7:0]         dac_data_in,
    input  var logic               dac_data_in_valid_stb,
    output var logic               dac_data_in_updated_stb,
    input  var logic               en_mmi_ctrl,
    output var dac_pkg::spi_pins_t spi,
    output var logic               init_done
);

    import dac_pkg::*;

    dac_word_t dac_word;
    logic      update_req;
    logic      frame_start;
    logic      frame_done;
    logic      sclk_rise;
    logic      sclk_fall;

    dac_regs #(
        .DAC_DEFAULT (DAC_DEFAULT)
    ) i_dac_regs (
        .clk                   (clk),
        .peripheral_sreset     (peripheral_sreset),
        .en_mmi_ctrl           (en_mmi_ctrl),
        .mmi_req               (mmi_req),
        .mmi_rsp               (mmi_rsp),
        .dac_data_in           (dac_data_in),
        .dac_data_in_valid_stb (dac_data_in_valid_stb),
        .dac_word              (dac_word),
        .update_req            (update_req)
    );

    dac_update_fsm #(
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET)
    ) i_dac_update_fsm (
        .clk                     (clk),
        .peripheral_sreset       (peripheral_sreset),
        .update_req              (update_req),
        .frame_done              (frame_done),
        .frame_start             (frame_start),
        .init_done               (init_done),
        .dac_data_in_updated_stb (dac_data_in_updated_stb)
    );

    spi_bit_timer #(
        .SCLK_DIV (SCLK_DIV)
    ) i_spi_bit_timer (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .frame_start       (frame_start),
        .sclk_rise         (sclk_rise),
        .sclk_fall         (sclk_fall),
        .frame_done        (frame_done)
    );

    spi_shifter i_spi_shifter (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .frame_start       (frame_start),
        .sclk_rise         (sclk_rise),
        .sclk_fall         (sclk_fall),
        .frame_done        (frame_done),
        .dac_word          (dac_word),
        .spi               (spi)
    );

endmodule

`default_nettype wire

/* dv/tb_dac_ad5601.sv */
//////////////////////////////////////////////////////////////////////
// runs dv/dac_tests.txt from the project root; SCLK_DIV and the default
// word here must match the expected frames in that file
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_dac_ad5601;

    import dac_pkg::*;

    localparam int SCLK_DIV = 2;

    logic       clk;
    logic       peripheral_sreset;
    mmi_req_t   mmi_req;
    mmi_rsp_t   mmi_rsp;
    logic [7:0] dac_data_in;
    logic       dac_data_in_valid_stb;
    logic       dac_data_in_updated_stb;
    logic       en_mmi_ctrl;
    spi_pins_t  spi;
    logic       init_done;

    // test table as read from the file
    string       t_name[$];
    string       t_op[$];
    logic [15:0] t_arg[$];
    logic [15:0] t_exp[$];

    logic [15:0] frames[$];
    logic [15:0] rx_shift;
    logic        prev_sclk;
    int          rx_bits;
    int          upd_cnt;
    int          frames_checked;
    int          errors;
    int          failed_tests;
    int          limit;
    int          cycles;

    dac_ad5601_top #(
        .SET_DEFAULT_ON_RESET (1'b1),
        .DAC_DEFAULT          ('{mode: MODE_NORMAL, data: 8'h80, rsvd: 6'h00}),
        .SCLK_DIV             (SCLK_DIV)
    ) i_dac_ad5601_top (
        .clk                     (clk),
        .peripheral_sreset       (peripheral_sreset),
        .mmi_req                 (mmi_req),
        .mmi_rsp                 (mmi_rsp),
        .dac_data_in             (dac_data_in),
        .dac_data_in_valid_stb   (dac_data_in_valid_stb),
        .dac_data_in_updated_stb (dac_data_in_updated_stb),
        .en_mmi_ctrl             (en_mmi_ctrl),
        .spi                     (spi),
        .init_done               (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // SPI frame decoder, pins sampled mid-cycle

    always @(negedge clk) begin
        if (peripheral_sreset) begin
            rx_bits = 0;
        end else begin
            // DAC samples on the falling SCLK edge
            if (!spi.ssn && prev_sclk && !spi.sclk) begin
                rx_shift = {rx_shift[14:0], spi.mosi};
                rx_bits  = rx_bits + 1;
                if (rx_bits == 16) begin
                    frames.push_back(rx_shift);
                    rx_bits = 0;
                end
            end
            if (dac_data_in_updated_stb) begin
                upd_cnt = upd_cnt + 1;
            end
        end
        prev_sclk = spi.sclk;
    end

    initial begin : watchdog
        cycles = 0;
        while (limit == 0 || cycles < limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // bus and stream drivers

    task automatic bus_write(input logic [3:0] addr, input logic [15:0] data);
        @(posedge clk);
        mmi_req.wvalid <= 1'b1;
        mmi_req.waddr  <= addr;
        mmi_req.wdata  <= data;
        @(negedge clk);
        while (!mmi_rsp.wready) @(negedge clk);
        @(posedge clk);
        mmi_req.wvalid <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [15:0] data);
        @(posedge clk);
        mmi_req.arvalid <= 1'b1;
        mmi_req.raddr   <= addr;
        mmi_req.rready  <= 1'b1;
        @(negedge clk);
        while (!mmi_rsp.arready) @(negedge clk);
        @(posedge clk);
        mmi_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!mmi_rsp.rvalid) @(negedge clk);
        data = mmi_rsp.rdata;
        @(posedge clk);
        mmi_req.rready <= 1'b0;
    endtask

    task automatic stream_byte(input logic [7:0] value);
        @(posedge clk);
        dac_data_in           <= value;
        dac_data_in_valid_stb <= 1'b1;
        @(posedge clk);
        dac_data_in_valid_stb <= 1'b0;
    endtask

    task automatic set_ctrl(input logic level);
        @(posedge clk);
        en_mmi_ctrl <= level;
        // register 2 follows one cycle later
        repeat (2) @(posedge clk);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one line of the test file

    task automatic run_test(input string name, input string op,
                            input logic [15:0] arg, input logic [15:0] exp);
        logic [15:0] got;
        int          errors_before;
        errors_before = errors;
        if (op == "wr") begin
            bus_write(arg[3:0], exp);
        end else if (op == "rd") begin
            bus_read(arg[3:0], got);
            check_value(name, exp, got);
        end else if (op == "strm") begin
            stream_byte(arg[7:0]);
        end else if (op == "ctrl") begin
            set_ctrl(arg[0]);
        end else if (op == "wait_frame") begin
            while (frames.size() <= frames_checked || upd_cnt <= frames_checked) begin
                @(posedge clk);
            end
            assert (init_done) else begin
                $display("init_done still low after a finished frame in %s", name);
                errors = errors + 1;
            end
            // one strobe per frame so far
            assert (upd_cnt == frames_checked + 1) else begin
                $display("Mismatch in %s: expected %0d updated strobes, actual %0d",
                         name, frames_checked + 1, upd_cnt);
                errors = errors + 1;
            end
            check_value(name, exp, frames[frames_checked]);
            frames_checked = frames_checked + 1;
        end else if (op == "burst") begin
            // both writes land while the current frame shifts
            @(negedge clk);
            while (spi.ssn) @(negedge clk);
            bus_write(4'(ADDR_DAC_REG), arg);
            bus_write(4'(ADDR_DAC_REG), exp);
        end else if (op == "quiet") begin
            repeat (arg) @(posedge clk);
            check_value(name, exp, 16'(frames.size()));
            check_value(name, exp, 16'(upd_cnt));
        end else begin
            $display("unknown operation %s in test %s", op, name);
            errors = errors + 1;
        end
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
            failed_tests = failed_tests + 1;
        end
    endtask

    initial begin : main
        int          fd;
        int          n_lines;
        int          n_fields;
        string       line;
        string       name;
        string       op;
        logic [15:0] arg;
        logic [15:0] exp;
        peripheral_sreset     = 1'b1;
        mmi_req               = '0;
        dac_data_in           = '0;
        dac_data_in_valid_stb = 1'b0;
        en_mmi_ctrl           = 1'b1;
        prev_sclk             = 1'b1;
        rx_shift              = '0;
        rx_bits               = 0;
        upd_cnt               = 0;
        frames_checked        = 0;
        errors                = 0;
        failed_tests          = 0;
        limit                 = 0;
        fd = $fopen("dv/dac_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test file dv/dac_tests.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            n_lines = 0;
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    n_lines = n_lines + 1;
                    if (line.len() > 0 && line.getc(0) != "#") begin
                        n_fields = $sscanf(line, "%s %s %h %h", name, op, arg, exp);
                        if (n_fields == 4) begin
                            t_name.push_back(name);
                            t_op.push_back(op);
                            t_arg.push_back(arg);
                            t_exp.push_back(exp);
                        end
                    end
                end
            end
            $fclose(fd);
            // budget of one frame plus bus overhead per line
            limit = n_lines * (32 * SCLK_DIV + 20) + 200;

            repeat (2) @(posedge clk);
            peripheral_sreset <= 1'b0;

            if (t_name.size() == 0) begin
                $display("no tests found in dv/dac_tests.txt");
                errors = errors + 1;
            end
            for (int i = 0; i < t_name.size(); i++) begin
                run_test(t_name[i], t_op[i], t_arg[i], t_exp[i]);
            end

            $display("%0d tests, %0d failed, %0d errors, %0d frames, %0d updated strobes",
                     t_name.size(), failed_tests, errors, frames.size(), upd_cnt);
            if (errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

/* dv/dac_tests.txt */
# name op arg expected, hex; wr: addr data, rd: addr expected, strm: byte 0, ctrl: level 0
# wait_frame: 0 frame, burst: first_word last_word, quiet: cycles total_frames
reset_frame  wait_frame 0    2000
rd_version   rd         0    0001
rd_default   rd         1    2000
rd_ctrl_hi   rd         2    0001
rd_undef     rd         7    0000
wr_dac       wr         1    5ac3
frame_wr     wait_frame 0    5ac3
rd_dac       rd         1    5ac3
ctrl_lo      ctrl       0    0000
rd_ctrl_lo   rd         2    0000
strm_a5      strm       a5   0000
frame_strm   wait_frame 0    6943
rd_strm      rd         1    6943
wr_blocked   wr         1    1234
rd_blocked   rd         1    6943
no_frame     quiet      60   0003
ctrl_hi      ctrl       1    0000
wr_first     wr         1    0040
burst_wr     burst      8000 3fc0
frame_first  wait_frame 0    0040
frame_merged wait_frame 0    3fc0
rd_merged    rd         1    3fc0
one_merge    quiet      60   0005

/* all.f */
verilog/dac_pkg.sv
verilog/dac_regs.sv
verilog/dac_update_fsm.sv
verilog/spi_bit_timer.sv
verilog/spi_shifter.sv
verilog/dac_ad5601_top.sv
dv/tb_dac_ad5601.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the AD5601 controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_dac_ad5601 -Mdir obj_dir -o sim_tb -f all.f \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "*** FAILED ***" >> sim.log
cat sim.log

grep -qF "*** FAILED ***" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
